//--- design/lc_enc_pkg.sv
// Multibit enable encoding for life cycle broadcasts.
// Key manager diversification values.
// Broadcast struct and its reset value.

package lc_enc_pkg;

  // On and Off are bitwise inverses of each other.
  typedef logic [3:0] lc_tx_t;

  localparam lc_tx_t LcTxOn  = 4'b0101;
  localparam lc_tx_t LcTxOff = 4'b1010;

  localparam int unsigned LcKeymgrDivWidth = 16;

  typedef logic [LcKeymgrDivWidth-1:0] lc_keymgr_div_t;

  ////////////////////
  // Diversification values, one per state group.
  localparam lc_keymgr_div_t LcDivInvalid      = 16'h9f31;
  localparam lc_keymgr_div_t LcDivTestUnlocked = 16'h4c72;
  localparam lc_keymgr_div_t LcDivDev          = 16'h27e8;
  localparam lc_keymgr_div_t LcDivProduction   = 16'hb5d6;
  localparam lc_keymgr_div_t LcDivRma          = 16'h63ad;

  ////////////////////
  // Full set of broadcast signals.
  typedef struct packed {
    lc_tx_t         raw_test_rma;
    lc_tx_t         dft_en;
    lc_tx_t         nvm_debug_en;
    lc_tx_t         hw_debug_en;
    lc_tx_t         cpu_en;
    lc_tx_t         creator_seed_sw_rw_en;
    lc_tx_t         owner_seed_sw_rw_en;
    lc_tx_t         iso_part_sw_rd_en;
    lc_tx_t         iso_part_sw_wr_en;
    lc_tx_t         seed_hw_rd_en;
    lc_tx_t         keymgr_en;
    lc_tx_t         escalate_en;
    lc_keymgr_div_t keymgr_div;
  } lc_broadcast_t;

  // Everything disabled, invalid diversification.
  localparam lc_broadcast_t LcBroadcastOff = '{
    raw_test_rma:          LcTxOff,
    dft_en:                LcTxOff,
    nvm_debug_en:          LcTxOff,
    hw_debug_en:           LcTxOff,
    cpu_en:                LcTxOff,
    creator_seed_sw_rw_en: LcTxOff,
    owner_seed_sw_rw_en:   LcTxOff,
    iso_part_sw_rd_en:     LcTxOff,
    iso_part_sw_wr_en:     LcTxOff,
    seed_hw_rd_en:         LcTxOff,
    keymgr_en:             LcTxOff,
    escalate_en:           LcTxOff,
    keymgr_div:            LcDivInvalid
  };

endpackage

//--- design/lc_state_pkg.sv
// Life cycle state codes.
// Life cycle controller FSM states.
// State groups used by the enable table.

package lc_state_pkg;

  ////////////////////
  // Sparse life cycle state codes. Any other value is invalid.
  typedef enum logic [15:0] {
    LcStRaw           = 16'h3a5c,
    LcStTestLocked0   = 16'h5c93,
    LcStTestLocked1   = 16'h96e1,
    LcStTestLocked2   = 16'hc72e,
    LcStTestUnlocked0 = 16'h1bd4,
    LcStTestUnlocked1 = 16'h6e47,
    LcStTestUnlocked2 = 16'ha8f3,
    LcStTestUnlocked3 = 16'he19a,
    LcStDev           = 16'h2d7b,
    LcStProd          = 16'h74b6,
    LcStProdEnd       = 16'hb34d,
    LcStRma           = 16'hd9e5,
    LcStScrap         = 16'hffff
  } lc_state_e;

  ////////////////////
  // Controller FSM states.
  // Transition programming and token checks are merged into one state each.
  typedef enum logic [3:0] {
    ResetSt      = 4'h3,
    IdleSt       = 4'h5,
    TransProgSt  = 4'h6,
    TokenCheckSt = 4'h9,
    PostTransSt  = 4'ha,
    ScrapSt      = 4'hc,
    EscalateSt   = 4'he,
    InvalidSt    = 4'hf
  } fsm_state_e;

  ////////////////////
  // Groups of states that share one feature set.
  typedef enum logic [3:0] {
    // Nothing broadcast, no escalation.
    GrpSilent           = 4'h0,
    // RAW and TEST_LOCKED states.
    GrpRawLocked        = 4'h1,
    GrpTestUnlocked     = 4'h2,
    // Last TEST_UNLOCKED state, without NVM debug.
    GrpTestUnlockedLast = 4'h3,
    GrpDev              = 4'h4,
    // PROD and PROD_END.
    GrpProd             = 4'h5,
    GrpRma              = 4'h6,
    GrpEscalate         = 4'h7
  } lc_group_e;

endpackage

//--- design/lc_state_classify.sv
// State classifier for the life cycle signal decoder.
// Reduces FSM state, life cycle state and valid flag to a state group.

module lc_state_classify (
  input  lc_state_pkg::fsm_state_e fsm_state_i,
  input  logic                     lc_state_valid_i,
  input  lc_state_pkg::lc_state_e  lc_state_i,
  output lc_state_pkg::lc_group_e  group_o
);

  // Group picked from the life cycle state alone.
  lc_state_pkg::lc_group_e state_group;

  ////////////////////
  // Life cycle state to group.
  always_comb begin
    case (lc_state_i)
      lc_state_pkg::LcStRaw,
      lc_state_pkg::LcStTestLocked0,
      lc_state_pkg::LcStTestLocked1,
      lc_state_pkg::LcStTestLocked2: begin
        state_group = lc_state_pkg::GrpRawLocked;
      end
      lc_state_pkg::LcStTestUnlocked0,
      lc_state_pkg::LcStTestUnlocked1,
      lc_state_pkg::LcStTestUnlocked2: begin
        state_group = lc_state_pkg::GrpTestUnlocked;
      end
      // Last unlocked state before the mission states.
      lc_state_pkg::LcStTestUnlocked3: begin
        state_group = lc_state_pkg::GrpTestUnlockedLast;
      end
      lc_state_pkg::LcStDev: begin
        state_group = lc_state_pkg::GrpDev;
      end
      lc_state_pkg::LcStProd,
      lc_state_pkg::LcStProdEnd: begin
        state_group = lc_state_pkg::GrpProd;
      end
      lc_state_pkg::LcStRma: begin
        state_group = lc_state_pkg::GrpRma;
      end
      // Scrap and any code outside the table.
      default: begin
        state_group = lc_state_pkg::GrpEscalate;
      end
    endcase
  end

  ////////////////////
  // FSM state decides whether the life cycle state is used at all.
  always_comb begin
    case (fsm_state_i)
      // Nothing is broadcast before init or after a transition.
      lc_state_pkg::ResetSt,
      lc_state_pkg::PostTransSt: begin
        group_o = lc_state_pkg::GrpSilent;
      end
      lc_state_pkg::IdleSt,
      lc_state_pkg::TransProgSt,
      lc_state_pkg::TokenCheckSt: begin
        if (lc_state_valid_i) begin
          group_o = state_group;
        end else begin
          group_o = lc_state_pkg::GrpEscalate;
        end
      end
      // Scrap, escalate, invalid and unknown FSM codes.
      default: begin
        group_o = lc_state_pkg::GrpEscalate;
      end
    endcase
  end

endmodule

//--- design/lc_enable_table.sv
// Enable table for the life cycle signal decoder.
// Maps a state group and secrets valid to the broadcast set
// and the key manager diversification value.

module lc_enable_table (
  input  lc_state_pkg::lc_group_e  group_i,
  input  lc_enc_pkg::lc_tx_t       secrets_valid_i,
  output lc_enc_pkg::lc_broadcast_t next_broadcast_o
);

  // Creator seed access closes once secrets are valid.
  // Inversion turns On into Off with this encoding.
  lc_enc_pkg::lc_tx_t creator_seed_en;

  assign creator_seed_en = lc_enc_pkg::lc_tx_t'(~secrets_valid_i);

  always_comb begin
    // Everything Off unless the group turns it on.
    next_broadcast_o = lc_enc_pkg::LcBroadcastOff;

    case (group_i)
      ////////////////////
      // OTP test access only.
      lc_state_pkg::GrpRawLocked: begin
        next_broadcast_o.raw_test_rma = lc_enc_pkg::LcTxOn;
      end
      ////////////////////
      // DFT, debug and CPU.
      lc_state_pkg::GrpTestUnlocked: begin
        next_broadcast_o.raw_test_rma      = lc_enc_pkg::LcTxOn;
        next_broadcast_o.dft_en            = lc_enc_pkg::LcTxOn;
        next_broadcast_o.nvm_debug_en      = lc_enc_pkg::LcTxOn;
        next_broadcast_o.hw_debug_en       = lc_enc_pkg::LcTxOn;
        next_broadcast_o.cpu_en            = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_wr_en = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_div        = lc_enc_pkg::LcDivTestUnlocked;
      end
      // Same set, NVM debug stays Off.
      lc_state_pkg::GrpTestUnlockedLast: begin
        next_broadcast_o.raw_test_rma      = lc_enc_pkg::LcTxOn;
        next_broadcast_o.dft_en            = lc_enc_pkg::LcTxOn;
        next_broadcast_o.hw_debug_en       = lc_enc_pkg::LcTxOn;
        next_broadcast_o.cpu_en            = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_wr_en = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_div        = lc_enc_pkg::LcDivTestUnlocked;
      end
      ////////////////////
      // Production functions.
      lc_state_pkg::GrpProd: begin
        next_broadcast_o.cpu_en                = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_en             = lc_enc_pkg::LcTxOn;
        next_broadcast_o.owner_seed_sw_rw_en   = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_wr_en     = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_rd_en     = lc_enc_pkg::LcTxOn;
        next_broadcast_o.creator_seed_sw_rw_en = creator_seed_en;
        next_broadcast_o.seed_hw_rd_en         = secrets_valid_i;
        next_broadcast_o.keymgr_div            = lc_enc_pkg::LcDivProduction;
      end
      // Like PROD, plus CPU debug, without isolated partition reads.
      lc_state_pkg::GrpDev: begin
        next_broadcast_o.hw_debug_en           = lc_enc_pkg::LcTxOn;
        next_broadcast_o.cpu_en                = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_en             = lc_enc_pkg::LcTxOn;
        next_broadcast_o.owner_seed_sw_rw_en   = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_wr_en     = lc_enc_pkg::LcTxOn;
        next_broadcast_o.creator_seed_sw_rw_en = creator_seed_en;
        next_broadcast_o.seed_hw_rd_en         = secrets_valid_i;
        next_broadcast_o.keymgr_div            = lc_enc_pkg::LcDivDev;
      end
      ////////////////////
      // All test and production functions.
      lc_state_pkg::GrpRma: begin
        next_broadcast_o.raw_test_rma          = lc_enc_pkg::LcTxOn;
        next_broadcast_o.dft_en                = lc_enc_pkg::LcTxOn;
        next_broadcast_o.nvm_debug_en          = lc_enc_pkg::LcTxOn;
        next_broadcast_o.hw_debug_en           = lc_enc_pkg::LcTxOn;
        next_broadcast_o.cpu_en                = lc_enc_pkg::LcTxOn;
        next_broadcast_o.creator_seed_sw_rw_en = lc_enc_pkg::LcTxOn;
        next_broadcast_o.owner_seed_sw_rw_en   = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_rd_en     = lc_enc_pkg::LcTxOn;
        next_broadcast_o.iso_part_sw_wr_en     = lc_enc_pkg::LcTxOn;
        next_broadcast_o.seed_hw_rd_en         = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_en             = lc_enc_pkg::LcTxOn;
        next_broadcast_o.keymgr_div            = lc_enc_pkg::LcDivRma;
      end
      // Escalation request for this cycle only.
      lc_state_pkg::GrpEscalate: begin
        next_broadcast_o.escalate_en = lc_enc_pkg::LcTxOn;
      end
      // Silent group keeps the defaults.
      default: ;
    endcase
  end

endmodule

//--- design/lc_broadcast_regs.sv
// Output registers for the life cycle broadcast.
// Sticky escalation, held On until reset.

module lc_broadcast_regs (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  lc_enc_pkg::lc_broadcast_t next_broadcast_i,
  output lc_enc_pkg::lc_broadcast_t broadcast_o
);

  lc_enc_pkg::lc_broadcast_t broadcast_q;

  // Escalation request merged with the held value.
  lc_enc_pkg::lc_tx_t escalate_d;

  logic escalate_req;
  logic escalate_held;

  ////////////////////
  // Sticky escalation.
  assign escalate_req  = (next_broadcast_i.escalate_en == lc_enc_pkg::LcTxOn);
  assign escalate_held = (broadcast_q.escalate_en == lc_enc_pkg::LcTxOn);

  // Any On, from either side, keeps the output On.
  assign escalate_d = (escalate_req || escalate_held) ? lc_enc_pkg::LcTxOn
                                                      : lc_enc_pkg::LcTxOff;

  ////////////////////
  // Broadcast register.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      broadcast_q <= lc_enc_pkg::LcBroadcastOff;
    end else begin
      broadcast_q             <= next_broadcast_i;
      broadcast_q.escalate_en <= escalate_d;
    end
  end

  assign broadcast_o = broadcast_q;

endmodule

//--- design/lc_signal_decode.sv
// Top level of the life cycle signal decoder.
// Classifier, enable table and output registers.

module lc_signal_decode (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      lc_state_valid_i,
  input  lc_state_pkg::lc_state_e   lc_state_i,
  input  lc_state_pkg::fsm_state_e  fsm_state_i,
  input  lc_enc_pkg::lc_tx_t        secrets_valid_i,
  output lc_enc_pkg::lc_broadcast_t broadcast_o
);

  lc_state_pkg::lc_group_e   group;
  // Escalation in here is this cycle's request only.
  lc_enc_pkg::lc_broadcast_t next_broadcast;

  ////////////////////
  // Combinational decode.
  lc_state_classify u_classify (
    .fsm_state_i      (fsm_state_i),
    .lc_state_valid_i (lc_state_valid_i),
    .lc_state_i       (lc_state_i),
    .group_o          (group)
  );

  lc_enable_table u_enable_table (
    .group_i          (group),
    .secrets_valid_i  (secrets_valid_i),
    .next_broadcast_o (next_broadcast)
  );

  ////////////////////
  // One cycle of latency to the outputs.
  lc_broadcast_regs u_broadcast_regs (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .next_broadcast_i (next_broadcast),
    .broadcast_o      (broadcast_o)
  );

endmodule

//--- sim/lc_clock_gen.sv
// Free-running testbench clock.
// Period of 100 time units, starts low.

module lc_clock_gen (
  output logic clk_o
);

  localparam int unsigned HalfPeriod = 50;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HalfPeriod) clk_o = ~clk_o;
    end
  end

endmodule

//--- sim/lc_signal_decode_asserts.sv
// Bound checks for the life cycle signal decoder.
// Reference model of the enable rules, reset values and sticky escalation.

module lc_signal_decode_asserts (
  input logic                      clk_i,
  input logic                      reset_i,
  input logic                      lc_state_valid_i,
  input lc_state_pkg::lc_state_e   lc_state_i,
  input lc_state_pkg::fsm_state_e  fsm_state_i,
  input lc_enc_pkg::lc_tx_t        secrets_valid_i,
  input lc_enc_pkg::lc_broadcast_t broadcast_i
);

  int unsigned reset_fails = 0;
  int unsigned feature_fails = 0;
  int unsigned escalate_fails = 0;
  int unsigned held_fails = 0;
  int unsigned fail_count;

  logic                      armed_q = 1'b0;
  logic                      reset_q;
  logic                      escalate_q;
  lc_enc_pkg::lc_broadcast_t expected_now;
  lc_enc_pkg::lc_broadcast_t expected_q;

  assign fail_count = reset_fails + feature_fails + escalate_fails + held_fails;

  function automatic lc_enc_pkg::lc_tx_t on_if(input logic cond);
    return cond ? lc_enc_pkg::LcTxOn : lc_enc_pkg::LcTxOff;
  endfunction

  function automatic lc_enc_pkg::lc_broadcast_t all_off();
    lc_enc_pkg::lc_broadcast_t value;
    value = {{12{lc_enc_pkg::LcTxOff}}, lc_enc_pkg::LcDivInvalid};
    return value;
  endfunction

  // Escalation is checked on its own.
  function automatic lc_enc_pkg::lc_broadcast_t features_of(input lc_enc_pkg::lc_broadcast_t b);
    lc_enc_pkg::lc_broadcast_t value;
    value = b;
    value.escalate_en = lc_enc_pkg::LcTxOff;
    return value;
  endfunction

  ////////////////////
  // Expected broadcast for one set of inputs, escalation as a request.
  function automatic lc_enc_pkg::lc_broadcast_t expected_set(
    input lc_state_pkg::fsm_state_e fsm,
    input logic                     valid,
    input lc_state_pkg::lc_state_e  state,
    input lc_enc_pkg::lc_tx_t       secrets
  );
    lc_enc_pkg::lc_broadcast_t model;
    logic use_state;
    logic locked, unlocked, last, dev, prod, rma, seeds;
    use_state = valid && (fsm inside {lc_state_pkg::IdleSt, lc_state_pkg::TransProgSt,
                                      lc_state_pkg::TokenCheckSt});
    locked   = use_state && (state inside {lc_state_pkg::LcStRaw, lc_state_pkg::LcStTestLocked0,
                                           lc_state_pkg::LcStTestLocked1,
                                           lc_state_pkg::LcStTestLocked2});
    unlocked = use_state && (state inside {lc_state_pkg::LcStTestUnlocked0,
                                           lc_state_pkg::LcStTestUnlocked1,
                                           lc_state_pkg::LcStTestUnlocked2});
    last     = use_state && (state == lc_state_pkg::LcStTestUnlocked3);
    dev      = use_state && (state == lc_state_pkg::LcStDev);
    prod     = use_state && (state inside {lc_state_pkg::LcStProd, lc_state_pkg::LcStProdEnd});
    rma      = use_state && (state == lc_state_pkg::LcStRma);
    seeds    = dev || prod;
    model = all_off();
    model.raw_test_rma        = on_if(locked || unlocked || last || rma);
    model.dft_en              = on_if(unlocked || last || rma);
    model.nvm_debug_en        = on_if(unlocked || rma);
    model.hw_debug_en         = on_if(unlocked || last || dev || rma);
    model.cpu_en              = on_if(unlocked || last || seeds || rma);
    model.owner_seed_sw_rw_en = on_if(seeds || rma);
    model.iso_part_sw_rd_en   = on_if(prod || rma);
    model.iso_part_sw_wr_en   = on_if(unlocked || last || seeds || rma);
    model.keymgr_en           = on_if(seeds || rma);
    // Seed access follows secrets valid in DEV and PROD.
    model.creator_seed_sw_rw_en = rma ? lc_enc_pkg::LcTxOn
                                      : (seeds ? ~secrets : lc_enc_pkg::LcTxOff);
    model.seed_hw_rd_en = rma ? lc_enc_pkg::LcTxOn : (seeds ? secrets : lc_enc_pkg::LcTxOff);
    model.escalate_en = on_if(!(fsm inside {lc_state_pkg::ResetSt, lc_state_pkg::PostTransSt}) &&
                              !(locked || unlocked || last || seeds || rma));
    if (unlocked || last) begin
      model.keymgr_div = lc_enc_pkg::LcDivTestUnlocked;
    end else if (dev) begin
      model.keymgr_div = lc_enc_pkg::LcDivDev;
    end else if (prod) begin
      model.keymgr_div = lc_enc_pkg::LcDivProduction;
    end else if (rma) begin
      model.keymgr_div = lc_enc_pkg::LcDivRma;
    end
    return model;
  endfunction

  assign expected_now = expected_set(fsm_state_i, lc_state_valid_i, lc_state_i, secrets_valid_i);

  // Model state, one cycle behind the inputs like the outputs.
  always @(posedge clk_i) begin
    armed_q    <= 1'b1;
    reset_q    <= reset_i;
    expected_q <= expected_now;
    if (reset_i) begin
      escalate_q <= 1'b0;
    end else begin
      escalate_q <= escalate_q || (expected_now.escalate_en == lc_enc_pkg::LcTxOn);
    end
  end

  ////////////////////
  a_reset_values: assert property (@(posedge clk_i)
    armed_q && reset_q |-> broadcast_i == all_off())
    else begin
      $error("FAILED reset_values: expected %h, actual %h", all_off(), $sampled(broadcast_i));
      reset_fails = reset_fails + 1;
    end

  a_feature_set: assert property (@(posedge clk_i)
    armed_q && !reset_q |-> features_of(broadcast_i) == features_of(expected_q))
    else begin
      $error("FAILED feature_set: expected %h, actual %h",
             features_of($sampled(expected_q)), features_of($sampled(broadcast_i)));
      feature_fails = feature_fails + 1;
    end

  a_escalate: assert property (@(posedge clk_i)
    armed_q && !reset_q |-> broadcast_i.escalate_en == on_if(escalate_q))
    else begin
      $error("FAILED escalate: expected %h, actual %h",
             on_if($sampled(escalate_q)), $sampled(broadcast_i.escalate_en));
      escalate_fails = escalate_fails + 1;
    end

  // Once On, escalation only leaves through reset.
  a_escalate_held: assert property (@(posedge clk_i)
    armed_q && !reset_i && broadcast_i.escalate_en == lc_enc_pkg::LcTxOn
    |=> broadcast_i.escalate_en == lc_enc_pkg::LcTxOn)
    else begin
      $error("escalate_en dropped from On without a reset");
      held_fails = held_fails + 1;
    end

endmodule

//--- sim/tb_lc_signal_decode.sv
// Testbench for the life cycle signal decoder.
// Directed tests per state group, escalation tests and a random sweep.

module tb_lc_signal_decode;

  localparam int unsigned CycleLimit = 1000;

  logic                      clk;
  logic                      reset;
  logic                      lc_state_valid;
  lc_state_pkg::lc_state_e   lc_state;
  lc_state_pkg::fsm_state_e  fsm_state;
  lc_enc_pkg::lc_tx_t        secrets_valid;
  lc_enc_pkg::lc_broadcast_t broadcast;

  int unsigned tests_run = 0;
  int unsigned tests_failed = 0;
  int unsigned fails_before = 0;

  // Every legal life cycle state except scrap.
  lc_state_pkg::lc_state_e legal_states [12] = '{
    lc_state_pkg::LcStRaw, lc_state_pkg::LcStTestLocked0, lc_state_pkg::LcStTestLocked1,
    lc_state_pkg::LcStTestLocked2, lc_state_pkg::LcStTestUnlocked0,
    lc_state_pkg::LcStTestUnlocked1, lc_state_pkg::LcStTestUnlocked2,
    lc_state_pkg::LcStTestUnlocked3, lc_state_pkg::LcStDev, lc_state_pkg::LcStProd,
    lc_state_pkg::LcStProdEnd, lc_state_pkg::LcStRma
  };

  lc_state_pkg::fsm_state_e fsm_codes [8] = '{
    lc_state_pkg::ResetSt, lc_state_pkg::IdleSt, lc_state_pkg::TransProgSt,
    lc_state_pkg::TokenCheckSt, lc_state_pkg::PostTransSt, lc_state_pkg::ScrapSt,
    lc_state_pkg::EscalateSt, lc_state_pkg::InvalidSt
  };

  lc_clock_gen u_clock_gen (
    .clk_o (clk)
  );

  lc_signal_decode lc_signal_decode_i (
    .clk_i            (clk),
    .reset_i          (reset),
    .lc_state_valid_i (lc_state_valid),
    .lc_state_i       (lc_state),
    .fsm_state_i      (fsm_state),
    .secrets_valid_i  (secrets_valid),
    .broadcast_o      (broadcast)
  );

  bind lc_signal_decode lc_signal_decode_asserts u_asserts (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .lc_state_valid_i (lc_state_valid_i),
    .lc_state_i       (lc_state_i),
    .fsm_state_i      (fsm_state_i),
    .secrets_valid_i  (secrets_valid_i),
    .broadcast_i      (broadcast_o)
  );

  task automatic abort_run(input string reason);
    $display("Run stopped: %s", reason);
    $display("Verification failed");
    $finish;
  endtask

  // Advances to the falling edge, where inputs change and outputs are stable.
  task automatic step_cycles(input int unsigned count);
    int unsigned waited;
    waited = 0;
    while (waited < count) begin
      if (waited >= CycleLimit) begin
        abort_run("cycle wait ran past its limit");
      end
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic wait_for_escalate();
    int unsigned waited;
    waited = 0;
    while (broadcast.escalate_en != lc_enc_pkg::LcTxOn) begin
      if (waited >= 8) begin
        abort_run("escalate_en did not turn On after an escalation cause");
      end
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic drive_inputs(input lc_state_pkg::fsm_state_e fsm, input logic valid,
                              input lc_state_pkg::lc_state_e state, input lc_enc_pkg::lc_tx_t sv);
    fsm_state      = fsm;
    lc_state_valid = valid;
    lc_state       = state;
    secrets_valid  = sv;
    step_cycles(1);
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    step_cycles(5);
    reset = 1'b0;
  endtask

  // Cause, return to DEV, then check that escalation outlasts other inputs.
  task automatic escalate_case(input lc_state_pkg::fsm_state_e fsm, input logic valid,
                               input lc_state_pkg::lc_state_e state);
    drive_inputs(fsm, valid, state, lc_enc_pkg::LcTxOn);
    drive_inputs(lc_state_pkg::IdleSt, 1'b1, lc_state_pkg::LcStDev, lc_enc_pkg::LcTxOn);
    wait_for_escalate();
    drive_inputs(lc_state_pkg::ResetSt, 1'b1, lc_state_pkg::LcStRma, lc_enc_pkg::LcTxOff);
    drive_inputs(lc_state_pkg::IdleSt, 1'b1, lc_state_pkg::LcStRma, lc_enc_pkg::LcTxOff);
    apply_reset();
  endtask

  task automatic report_test(input string name);
    int unsigned fails;
    step_cycles(2);
    fails = lc_signal_decode_i.u_asserts.fail_count - fails_before;
    fails_before = lc_signal_decode_i.u_asserts.fail_count;
    tests_run++;
    if (fails == 0) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s: assertions failed %0d times", name, fails);
    end
  endtask

  // Mostly known FSM codes, an unknown one now and then.
  function automatic lc_state_pkg::fsm_state_e pick_fsm_state();
    int unsigned idx;
    idx = $urandom_range(8);
    return (idx < 8) ? fsm_codes[idx] : lc_state_pkg::fsm_state_e'(4'h0);
  endfunction

  function automatic lc_state_pkg::lc_state_e pick_lc_state();
    int unsigned idx;
    idx = $urandom_range(13);
    if (idx < 12) begin
      return legal_states[idx];
    end else if (idx == 12) begin
      return lc_state_pkg::LcStScrap;
    end
    return lc_state_pkg::lc_state_e'(16'($urandom()));
  endfunction

  initial begin
    void'($urandom(32'h9497124a));
    reset          = 1'b1;
    lc_state_valid = 1'b1;
    lc_state       = lc_state_pkg::LcStRma;
    fsm_state      = lc_state_pkg::IdleSt;
    secrets_valid  = lc_enc_pkg::LcTxOff;

    // Enabling inputs stay hidden while reset is high.
    step_cycles(5);
    reset = 1'b0;
    report_test("reset_values");

    for (int f = 1; f < 4; f++) begin
      for (int i = 0; i < 12; i++) begin
        drive_inputs(fsm_codes[f], 1'b1, legal_states[i], lc_enc_pkg::LcTxOn);
      end
    end
    report_test("group_sets");

    for (int i = 0; i < 8; i++) begin
      drive_inputs(lc_state_pkg::IdleSt, 1'b1,
                   (i >= 4) ? lc_state_pkg::LcStProd : lc_state_pkg::LcStDev,
                   i[0] ? lc_enc_pkg::LcTxOn : lc_enc_pkg::LcTxOff);
    end
    report_test("secrets_gating");

    for (int i = 0; i < 14; i++) begin
      drive_inputs(i[0] ? lc_state_pkg::ResetSt : lc_state_pkg::PostTransSt, i[1],
                   (i < 12) ? legal_states[i] : lc_state_pkg::lc_state_e'(16'h0000),
                   lc_enc_pkg::LcTxOn);
    end
    drive_inputs(lc_state_pkg::PostTransSt, 1'b1, lc_state_pkg::LcStScrap, lc_enc_pkg::LcTxOn);
    report_test("silent_states");

    ////////////////////
    escalate_case(lc_state_pkg::IdleSt, 1'b1, lc_state_pkg::lc_state_e'(16'h0000));
    escalate_case(lc_state_pkg::TokenCheckSt, 1'b0, lc_state_pkg::LcStDev);
    escalate_case(lc_state_pkg::TransProgSt, 1'b1, lc_state_pkg::LcStScrap);
    escalate_case(lc_state_pkg::ScrapSt, 1'b1, lc_state_pkg::LcStDev);
    escalate_case(lc_state_pkg::EscalateSt, 1'b1, lc_state_pkg::LcStDev);
    escalate_case(lc_state_pkg::InvalidSt, 1'b1, lc_state_pkg::LcStDev);
    escalate_case(lc_state_pkg::fsm_state_e'(4'h0), 1'b1, lc_state_pkg::LcStDev);
    report_test("escalation");

    // Occasional resets clear escalation so the sweep keeps moving.
    for (int n = 0; n < 200; n++) begin
      reset = ($urandom_range(15) == 0);
      drive_inputs(pick_fsm_state(), $urandom_range(7) != 0, pick_lc_state(),
                   ($urandom_range(1) != 0) ? lc_enc_pkg::LcTxOn : lc_enc_pkg::LcTxOff);
    end
    reset = 1'b0;
    report_test("random_sweep");

    $display("Tests run: %0d, passed: %0d, failed: %0d",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- sim.f
design/lc_enc_pkg.sv
design/lc_state_pkg.sv
design/lc_state_classify.sv
design/lc_enable_table.sv
design/lc_broadcast_regs.sv
design/lc_signal_decode.sv
sim/lc_clock_gen.sv
sim/lc_signal_decode_asserts.sv
sim/tb_lc_signal_decode.sv

//--- Makefile
TOP := tb_lc_signal_decode

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
